/* design/mem_bus_pkg.sv */
// memory bus package
// shared widths, access size codes, timer register map and the byte-lane view
`default_nettype none

package mem_bus_pkg;

  // bus widths
  parameter int unsigned ADDR_W = 64;
  parameter int unsigned DATA_W = 64;
  parameter int unsigned STRB_W = DATA_W / 8;

  // access size, same encoding as the AXI size field
  typedef enum logic [1:0] {
    SIZE_B = 2'd0,
    SIZE_H = 2'd1,
    SIZE_W = 2'd2,
    SIZE_D = 2'd3
  } size_e;

  // one doubleword, seen whole or as byte lanes
  typedef union packed {
    logic [DATA_W-1:0]     dword;
    logic [STRB_W-1:0][7:0] lane;
  } bus_dword_u;

  // timer window layout
  parameter int unsigned TIMER_WIN_BYTES = 16;
  parameter logic [3:0]  MTIME_OFS       = 4'd0;
  parameter logic [3:0]  MTIMECMP_OFS    = 4'd8;

endpackage

`default_nettype wire

/* design/mem_req_if.sv */
// request/response bus between the arbiter and one target
// valid and request fields held until the one-cycle ready pulse
`default_nettype none

interface mem_req_if;
  import mem_bus_pkg::*;

  logic              valid;
  logic              wen;
  logic [ADDR_W-1:0] addr;
  size_e             size;
  logic [DATA_W-1:0] wdata;
  logic              ready;
  // valid only while ready is high
  logic [DATA_W-1:0] rdata;

  modport requester (
    output valid, wen, addr, size, wdata,
    input  ready, rdata
  );

  modport target (
    input  valid, wen, addr, size, wdata,
    output ready, rdata
  );

endinterface

`default_nettype wire

/* design/machine_timer.sv */
// machine timer with mtime and mtimecmp registers
// level interrupt once mtime reaches mtimecmp
`default_nettype none

module machine_timer (
  input  wire        clk,
  input  wire        rst_n,
  mem_req_if.target  bus,
  output logic       o_timer_int
);
  import mem_bus_pkg::*;

  logic [63:0]       mtime;
  logic [63:0]       mtimecmp;
  logic              ready_q;
  logic              int_q;
  logic [DATA_W-1:0] rdata_q;
  logic              accept;
  logic              sel_mtime;
  logic              sel_cmp;

  // a held valid is not taken again in its ready cycle
  assign accept    = bus.valid & ~ready_q;
  assign sel_mtime = bus.addr[3:0] == MTIME_OFS;
  assign sel_cmp   = bus.addr[3:0] == MTIMECMP_OFS;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ready_q  <= 1'b0;
      int_q    <= 1'b0;
      mtime    <= '0;
      mtimecmp <= '1;
    end else begin
      ready_q <= accept;
      int_q   <= mtime >= mtimecmp;
      if (accept && bus.wen && sel_mtime) begin
        mtime <= bus.wdata;
      end else begin
        mtime <= mtime + 64'd1;
      end
      if (accept && bus.wen && sel_cmp) begin
        mtimecmp <= bus.wdata;
      end
    end
  end

  // read value captured at accept
  always_ff @(posedge clk) begin
    if (accept) begin
      rdata_q <= sel_mtime ? mtime : (sel_cmp ? mtimecmp : '0);
    end
  end

  assign bus.ready   = ready_q;
  assign bus.rdata   = rdata_q;
  assign o_timer_int = int_q;

  a_ready_after_valid: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(bus.ready) |-> $past(bus.valid));

endmodule

`default_nettype wire

/* design/axi_master_fsm.sv */
// AXI master bridge, one single-beat transfer at a time
// read goes AR then R, write goes AW and W together then B
`default_nettype none

module axi_master_fsm (
  input  wire                             clk,
  input  wire                             rst_n,
  mem_req_if.target                       bus,
  output logic                            o_axi_aw_valid,
  input  wire                             i_axi_aw_ready,
  output logic [mem_bus_pkg::ADDR_W-1:0]  o_axi_aw_addr,
  output logic [2:0]                      o_axi_aw_size,
  output logic                            o_axi_w_valid,
  input  wire                             i_axi_w_ready,
  output logic [mem_bus_pkg::DATA_W-1:0]  o_axi_w_data,
  output logic [mem_bus_pkg::STRB_W-1:0]  o_axi_w_strb,
  input  wire                             i_axi_b_valid,
  output logic                            o_axi_b_ready,
  output logic                            o_axi_ar_valid,
  input  wire                             i_axi_ar_ready,
  output logic [mem_bus_pkg::ADDR_W-1:0]  o_axi_ar_addr,
  output logic [2:0]                      o_axi_ar_size,
  input  wire                             i_axi_r_valid,
  output logic                            o_axi_r_ready,
  input  wire [mem_bus_pkg::DATA_W-1:0]   i_axi_r_data
);
  import mem_bus_pkg::*;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_RD_ADDR,
    ST_RD_DATA,
    ST_WR_REQ,
    ST_WR_RESP
  } state_e;

  state_e            state_q;
  logic              ready_q;
  logic              aw_done_q;
  logic              w_done_q;
  logic              accept;
  logic              aw_hs;
  logic              w_hs;
  logic              r_hs;
  logic              b_hs;
  logic [2:0]        ofs;
  logic [3:0]        nbytes;
  bus_dword_u        src_u;
  bus_dword_u        lane_u;
  logic [STRB_W-1:0] strb;
  logic [ADDR_W-1:0] addr_q;
  size_e             size_q;
  logic [DATA_W-1:0] wdata_q;
  logic [STRB_W-1:0] strb_q;
  logic [DATA_W-1:0] rdata_q;

  // skip the request still held during its own ready cycle
  assign accept = (state_q == ST_IDLE) & bus.valid & ~ready_q;

  assign aw_hs = o_axi_aw_valid & i_axi_aw_ready;
  assign w_hs  = o_axi_w_valid & i_axi_w_ready;
  assign r_hs  = i_axi_r_valid & o_axi_r_ready;
  assign b_hs  = i_axi_b_valid & o_axi_b_ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q   <= ST_IDLE;
      ready_q   <= 1'b0;
      aw_done_q <= 1'b0;
      w_done_q  <= 1'b0;
    end else begin
      ready_q <= r_hs | b_hs;
      case (state_q)
        ST_IDLE: begin
          aw_done_q <= 1'b0;
          w_done_q  <= 1'b0;
          if (accept) begin
            state_q <= bus.wen ? ST_WR_REQ : ST_RD_ADDR;
          end
        end
        ST_RD_ADDR: if (i_axi_ar_ready) state_q <= ST_RD_DATA;
        ST_RD_DATA: if (r_hs) state_q <= ST_IDLE;
        ST_WR_REQ: begin
          aw_done_q <= aw_done_q | aw_hs;
          w_done_q  <= w_done_q | w_hs;
          if ((aw_done_q | aw_hs) && (w_done_q | w_hs)) begin
            state_q <= ST_WR_RESP;
          end
        end
        ST_WR_RESP: if (b_hs) state_q <= ST_IDLE;
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  assign ofs    = bus.addr[2:0];
  assign nbytes = 4'd1 << bus.size;

  // store bytes moved up to their address lanes
  always_comb begin
    src_u.dword  = bus.wdata;
    lane_u.dword = '0;
    strb         = '0;
    for (int i = 0; i < STRB_W; i++) begin
      if (i >= ofs && (i - ofs) < nbytes) begin
        lane_u.lane[i] = src_u.lane[i - ofs];
        strb[i]        = 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      addr_q  <= bus.addr;
      size_q  <= bus.size;
      wdata_q <= lane_u.dword;
      strb_q  <= strb;
    end
    if (r_hs) begin
      rdata_q <= i_axi_r_data;
    end
  end

  assign o_axi_ar_valid = state_q == ST_RD_ADDR;
  assign o_axi_ar_addr  = addr_q;
  assign o_axi_ar_size  = {1'b0, size_q};
  assign o_axi_r_ready  = state_q == ST_RD_DATA;

  assign o_axi_aw_valid = (state_q == ST_WR_REQ) & ~aw_done_q;
  assign o_axi_aw_addr  = addr_q;
  assign o_axi_aw_size  = {1'b0, size_q};
  assign o_axi_w_valid  = (state_q == ST_WR_REQ) & ~w_done_q;
  assign o_axi_w_data   = wdata_q;
  assign o_axi_w_strb   = strb_q;
  assign o_axi_b_ready  = state_q == ST_WR_RESP;

  assign bus.ready = ready_q;
  assign bus.rdata = rdata_q;

  a_ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
    o_axi_ar_valid && !i_axi_ar_ready |=> o_axi_ar_valid && $stable(o_axi_ar_addr));

  a_aw_drop: assert property (@(posedge clk) disable iff (!rst_n)
    aw_hs |=> !o_axi_aw_valid);

  a_w_drop: assert property (@(posedge clk) disable iff (!rst_n)
    w_hs |=> !o_axi_w_valid);

endmodule

`default_nettype wire

/* design/bus_arbiter.sv */
// bus arbiter for fetch and load/store
// fixed load/store priority, timer window decode, read data alignment
`default_nettype none

module bus_arbiter #(
  parameter logic [mem_bus_pkg::ADDR_W-1:0] TIMER_BASE = 64'h0200_4000
) (
  input  wire                             clk,
  input  wire                             rst_n,
  input  wire                             i_ifu_valid,
  input  wire [mem_bus_pkg::ADDR_W-1:0]   i_ifu_addr,
  output logic                            o_ifu_ready,
  output logic [31:0]                     o_ifu_instr,
  input  wire                             i_lsu_valid,
  input  wire                             i_lsu_wen,
  input  wire [mem_bus_pkg::ADDR_W-1:0]   i_lsu_addr,
  input  wire mem_bus_pkg::size_e         i_lsu_size,
  input  wire [mem_bus_pkg::DATA_W-1:0]   i_lsu_wdata,
  output logic                            o_lsu_ready,
  output logic [mem_bus_pkg::DATA_W-1:0]  o_lsu_rdata,
  mem_req_if.requester                    timer_bus,
  mem_req_if.requester                    ram_bus
);
  import mem_bus_pkg::*;

  logic              busy_q;
  logic              lsu_sel_q;
  logic [ADDR_W-1:0] req_addr;
  size_e             req_size;
  logic              hit_timer;
  logic              done;
  logic [2:0]        ofs;
  logic [3:0]        nbytes;
  bus_dword_u        raw_u;
  bus_dword_u        shift_u;

  // grant taken when idle, held until the target answers
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy_q    <= 1'b0;
      lsu_sel_q <= 1'b0;
    end else if (!busy_q) begin
      busy_q    <= i_lsu_valid | i_ifu_valid;
      lsu_sel_q <= i_lsu_valid;
    end else if (done) begin
      busy_q <= 1'b0;
    end
  end

  // fetch is always a word read
  assign req_addr = lsu_sel_q ? i_lsu_addr : i_ifu_addr;
  assign req_size = lsu_sel_q ? i_lsu_size : SIZE_W;

  assign hit_timer = (req_addr >= TIMER_BASE) &&
                     (req_addr < TIMER_BASE + TIMER_WIN_BYTES);

  assign timer_bus.valid = busy_q & hit_timer;
  assign timer_bus.wen   = lsu_sel_q & i_lsu_wen;
  assign timer_bus.addr  = req_addr;
  assign timer_bus.size  = req_size;
  assign timer_bus.wdata = i_lsu_wdata;

  assign ram_bus.valid = busy_q & ~hit_timer;
  assign ram_bus.wen   = lsu_sel_q & i_lsu_wen;
  assign ram_bus.addr  = req_addr;
  assign ram_bus.size  = req_size;
  assign ram_bus.wdata = i_lsu_wdata;

  assign done = busy_q & (hit_timer ? timer_bus.ready : ram_bus.ready);

  assign o_lsu_ready = done & lsu_sel_q;
  assign o_ifu_ready = done & ~lsu_sel_q;

  assign ofs    = req_addr[2:0];
  assign nbytes = 4'd1 << req_size;

  // bring the addressed bytes down to lane 0, zero above the access size
  always_comb begin
    raw_u.dword   = hit_timer ? timer_bus.rdata : ram_bus.rdata;
    shift_u.dword = '0;
    for (int i = 0; i < STRB_W; i++) begin
      if ((i + ofs) < STRB_W && i < nbytes) begin
        shift_u.lane[i] = raw_u.lane[i + ofs];
      end
    end
  end

  assign o_lsu_rdata = shift_u.dword;
  assign o_ifu_instr = shift_u.dword[31:0];

  a_one_target: assert property (@(posedge clk) disable iff (!rst_n)
    !(timer_bus.valid && ram_bus.valid));

endmodule

`default_nettype wire

/* design/mem_subsys_top.sv */
// memory subsystem top level
// arbiter in front of the machine timer and the AXI master bridge
`default_nettype none

module mem_subsys_top #(
  parameter logic [mem_bus_pkg::ADDR_W-1:0] TIMER_BASE = 64'h0200_4000
) (
  input  wire                             clk,
  input  wire                             rst_n,
  // fetch port
  input  wire                             i_ifu_valid,
  input  wire [mem_bus_pkg::ADDR_W-1:0]   i_ifu_addr,
  output logic                            o_ifu_ready,
  output logic [31:0]                     o_ifu_instr,
  // load/store port
  input  wire                             i_lsu_valid,
  input  wire                             i_lsu_wen,
  input  wire [mem_bus_pkg::ADDR_W-1:0]   i_lsu_addr,
  input  wire mem_bus_pkg::size_e         i_lsu_size,
  input  wire [mem_bus_pkg::DATA_W-1:0]   i_lsu_wdata,
  output logic                            o_lsu_ready,
  output logic [mem_bus_pkg::DATA_W-1:0]  o_lsu_rdata,
  output logic                            o_timer_int,
  // AXI master
  output logic                            o_axi_aw_valid,
  input  wire                             i_axi_aw_ready,
  output logic [mem_bus_pkg::ADDR_W-1:0]  o_axi_aw_addr,
  output logic [2:0]                      o_axi_aw_size,
  output logic                            o_axi_w_valid,
  input  wire                             i_axi_w_ready,
  output logic [mem_bus_pkg::DATA_W-1:0]  o_axi_w_data,
  output logic [mem_bus_pkg::STRB_W-1:0]  o_axi_w_strb,
  input  wire                             i_axi_b_valid,
  output logic                            o_axi_b_ready,
  output logic                            o_axi_ar_valid,
  input  wire                             i_axi_ar_ready,
  output logic [mem_bus_pkg::ADDR_W-1:0]  o_axi_ar_addr,
  output logic [2:0]                      o_axi_ar_size,
  input  wire                             i_axi_r_valid,
  output logic                            o_axi_r_ready,
  input  wire [mem_bus_pkg::DATA_W-1:0]   i_axi_r_data
);

  mem_req_if timer_bus ();
  mem_req_if ram_bus ();

  bus_arbiter #(
    .TIMER_BASE (TIMER_BASE)
  ) u_bus_arbiter (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_ifu_valid (i_ifu_valid),
    .i_ifu_addr  (i_ifu_addr),
    .o_ifu_ready (o_ifu_ready),
    .o_ifu_instr (o_ifu_instr),
    .i_lsu_valid (i_lsu_valid),
    .i_lsu_wen   (i_lsu_wen),
    .i_lsu_addr  (i_lsu_addr),
    .i_lsu_size  (i_lsu_size),
    .i_lsu_wdata (i_lsu_wdata),
    .o_lsu_ready (o_lsu_ready),
    .o_lsu_rdata (o_lsu_rdata),
    .timer_bus   (timer_bus.requester),
    .ram_bus     (ram_bus.requester)
  );

  machine_timer u_machine_timer (
    .clk         (clk),
    .rst_n       (rst_n),
    .bus         (timer_bus.target),
    .o_timer_int (o_timer_int)
  );

  axi_master_fsm u_axi_master_fsm (
    .clk            (clk),
    .rst_n          (rst_n),
    .bus            (ram_bus.target),
    .o_axi_aw_valid (o_axi_aw_valid),
    .i_axi_aw_ready (i_axi_aw_ready),
    .o_axi_aw_addr  (o_axi_aw_addr),
    .o_axi_aw_size  (o_axi_aw_size),
    .o_axi_w_valid  (o_axi_w_valid),
    .i_axi_w_ready  (i_axi_w_ready),
    .o_axi_w_data   (o_axi_w_data),
    .o_axi_w_strb   (o_axi_w_strb),
    .i_axi_b_valid  (i_axi_b_valid),
    .o_axi_b_ready  (o_axi_b_ready),
    .o_axi_ar_valid (o_axi_ar_valid),
    .i_axi_ar_ready (i_axi_ar_ready),
    .o_axi_ar_addr  (o_axi_ar_addr),
    .o_axi_ar_size  (o_axi_ar_size),
    .i_axi_r_valid  (i_axi_r_valid),
    .o_axi_r_ready  (o_axi_r_ready),
    .i_axi_r_data   (i_axi_r_data)
  );

endmodule

`default_nettype wire

/* tb/axi_slave_model.sv */
// AXI memory model for the testbench
// 256 doublewords with byte strobes, each ready or response after 0 to 3 idle cycles
`default_nettype none

module axi_slave_model #(
  parameter int unsigned SEED = 32'h5224dd77
) (
  input  wire                            clk,
  input  wire                            i_aw_valid,
  output logic                           o_aw_ready,
  input  wire [mem_bus_pkg::ADDR_W-1:0]  i_aw_addr,
  input  wire                            i_w_valid,
  output logic                           o_w_ready,
  input  wire [mem_bus_pkg::DATA_W-1:0]  i_w_data,
  input  wire [mem_bus_pkg::STRB_W-1:0]  i_w_strb,
  output logic                           o_b_valid,
  input  wire                            i_b_ready,
  input  wire                            i_ar_valid,
  output logic                           o_ar_ready,
  input  wire [mem_bus_pkg::ADDR_W-1:0]  i_ar_addr,
  output logic                           o_r_valid,
  input  wire                            i_r_ready,
  output logic [mem_bus_pkg::DATA_W-1:0] o_r_data
);
  import mem_bus_pkg::*;

  logic [DATA_W-1:0] mem [256];
  logic [7:0]        aw_idx, ar_idx;
  logic [DATA_W-1:0] w_data;
  logic [STRB_W-1:0] w_strb;
  logic              aw_got, w_got, b_pend, b_fire, r_pend, r_fire;
  int                aw_cnt, w_cnt, ar_cnt, b_cnt, r_cnt;

  // true once a freshly drawn delay has run out
  function automatic logic delay_done(inout int cnt);
    if (cnt < 0) cnt = $urandom % 4;
    cnt--;
    return cnt < 0;
  endfunction

  initial begin
    void'($urandom(SEED));
    for (int i = 0; i < 256; i++) begin
      mem[i] = {32'hfeed_0000 | 32'(i), 32'(i) << 3};
    end
    {o_aw_ready, o_w_ready, o_b_valid, o_ar_ready, o_r_valid} = '0;
    o_r_data = '0;
    {aw_got, w_got, b_pend, b_fire, r_pend, r_fire} = '0;
    // all counters at -1, no delay running
    {aw_cnt, w_cnt, ar_cnt, b_cnt, r_cnt} = '1;
    forever begin
      @(negedge clk);
      // a ready raised last time means the handshake took place
      if (o_aw_ready) begin
        o_aw_ready = 1'b0;
        aw_got     = 1'b1;
      end else if (i_aw_valid && delay_done(aw_cnt)) begin
        o_aw_ready = 1'b1;
        aw_idx     = i_aw_addr[10:3];
      end
      if (o_w_ready) begin
        o_w_ready = 1'b0;
        w_got     = 1'b1;
      end else if (i_w_valid && delay_done(w_cnt)) begin
        o_w_ready = 1'b1;
        w_data    = i_w_data;
        w_strb    = i_w_strb;
      end
      if (aw_got && w_got) begin
        for (int i = 0; i < STRB_W; i++) begin
          if (w_strb[i]) mem[aw_idx][8*i +: 8] = w_data[8*i +: 8];
        end
        aw_got = 1'b0;
        w_got  = 1'b0;
        b_pend = 1'b1;
      end
      if (b_fire) begin
        o_b_valid = 1'b0;
      end else if (b_pend && delay_done(b_cnt)) begin
        o_b_valid = 1'b1;
        b_pend    = 1'b0;
      end
      // ready seen here holds until the next rising edge
      b_fire = o_b_valid && i_b_ready;
      if (o_ar_ready) begin
        o_ar_ready = 1'b0;
        r_pend     = 1'b1;
      end else if (i_ar_valid && delay_done(ar_cnt)) begin
        o_ar_ready = 1'b1;
        ar_idx     = i_ar_addr[10:3];
      end
      if (r_fire) begin
        o_r_valid = 1'b0;
      end else if (r_pend && delay_done(r_cnt)) begin
        o_r_valid = 1'b1;
        o_r_data  = mem[ar_idx];
        r_pend    = 1'b0;
      end
      r_fire = o_r_valid && i_r_ready;
    end
  end

endmodule

`default_nettype wire

/* tb/tb_mem_subsys.sv */
// testbench for the memory subsystem
// table of fetch and load/store accesses over an AXI memory model, then the timer
`default_nettype none

module tb_mem_subsys;
  import mem_bus_pkg::*;

  localparam logic [ADDR_W-1:0] TIMER_BASE = 64'h0200_4000;
  localparam int PORT_IFU   = 0;
  localparam int PORT_LSU   = 1;
  localparam int PORT_BOTH  = 2;
  localparam int WAIT_LIMIT = 200;

  logic              clk;
  logic              rst_n;
  logic              i_ifu_valid;
  logic [ADDR_W-1:0] i_ifu_addr;
  logic              o_ifu_ready;
  logic [31:0]       o_ifu_instr;
  logic              i_lsu_valid;
  logic              i_lsu_wen;
  logic [ADDR_W-1:0] i_lsu_addr;
  size_e             i_lsu_size;
  logic [DATA_W-1:0] i_lsu_wdata;
  logic              o_lsu_ready;
  logic [DATA_W-1:0] o_lsu_rdata;
  logic              o_timer_int;
  logic              o_axi_aw_valid, i_axi_aw_ready;
  logic              o_axi_w_valid, i_axi_w_ready;
  logic              i_axi_b_valid, o_axi_b_ready;
  logic              o_axi_ar_valid, i_axi_ar_ready;
  logic              i_axi_r_valid, o_axi_r_ready;
  logic [ADDR_W-1:0] o_axi_aw_addr, o_axi_ar_addr;
  logic [2:0]        o_axi_aw_size, o_axi_ar_size;
  logic [DATA_W-1:0] o_axi_w_data, i_axi_r_data;
  logic [STRB_W-1:0] o_axi_w_strb;

  // stimulus table, one entry per row in each queue
  string             row_name[$];
  int                row_port[$];
  logic              row_wen[$];
  logic [ADDR_W-1:0] row_addr[$];
  size_e             row_size[$];
  logic [DATA_W-1:0] row_wdata[$];
  logic [DATA_W-1:0] row_exp[$];
  logic [DATA_W-1:0] last_rdata;
  logic [DATA_W-1:0] cmp_value;
  int                wait_cycles;

  mem_subsys_top #(.TIMER_BASE (TIMER_BASE)) UUT (.*);

  axi_slave_model #(
    .SEED (32'h5224dd77)
  ) u_axi_slave_model (
    .clk        (clk),
    .i_aw_valid (o_axi_aw_valid),
    .o_aw_ready (i_axi_aw_ready),
    .i_aw_addr  (o_axi_aw_addr),
    .i_w_valid  (o_axi_w_valid),
    .o_w_ready  (i_axi_w_ready),
    .i_w_data   (o_axi_w_data),
    .i_w_strb   (o_axi_w_strb),
    .o_b_valid  (i_axi_b_valid),
    .i_b_ready  (o_axi_b_ready),
    .i_ar_valid (o_axi_ar_valid),
    .o_ar_ready (i_axi_ar_ready),
    .i_ar_addr  (o_axi_ar_addr),
    .o_r_valid  (i_axi_r_valid),
    .i_r_ready  (o_axi_r_ready),
    .o_r_data   (i_axi_r_data)
  );

  always #2 clk = ~clk;

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("tests failed");
    $fatal(1);
  endtask

  task automatic check_dword(input string name, input bus_dword_u exp, input bus_dword_u act);
    if (act.dword !== exp.dword) begin
      fail_run($sformatf("** Error %s: expected %h, actual %h", name, exp.dword, act.dword));
    end
  endtask

  task automatic check_instr(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      fail_run($sformatf("** Error %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic check_level(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      fail_run($sformatf("** Error %s: expected %b, actual %b", name, exp, act));
    end
  endtask

  task automatic check_axi_size(input string name, input logic [2:0] exp, input logic [2:0] act);
    if (act !== exp) begin
      fail_run($sformatf("** Error %s axi size: expected %0d, actual %0d", name, exp, act));
    end
  endtask

  task automatic add_row(input string name, input int port, input logic wen,
                         input logic [ADDR_W-1:0] addr, input size_e size,
                         input logic [DATA_W-1:0] wdata, input logic [DATA_W-1:0] exp);
    row_name.push_back(name);
    row_port.push_back(port);
    row_wen.push_back(wen);
    row_addr.push_back(addr);
    row_size.push_back(size);
    row_wdata.push_back(wdata);
    row_exp.push_back(exp);
  endtask

  // one access on either port or both, valids held until each ready
  task automatic run_access(input string name, input int port, input logic wen,
                            input logic [ADDR_W-1:0] addr, input size_e size,
                            input logic [DATA_W-1:0] wdata, input logic [DATA_W-1:0] exp,
                            input logic check_data);
    logic  lsu_pend;
    logic  ifu_pend;
    logic  in_timer;
    int    cycles;
    size_e exp_size;
    lsu_pend = port != PORT_IFU;
    ifu_pend = port != PORT_LSU;
    in_timer = addr >= TIMER_BASE && addr < TIMER_BASE + TIMER_WIN_BYTES;
    cycles   = 0;
    @(negedge clk);
    i_lsu_valid = lsu_pend;
    i_lsu_wen   = wen;
    i_lsu_addr  = addr;
    i_lsu_size  = size;
    i_lsu_wdata = wdata;
    i_ifu_valid = ifu_pend;
    i_ifu_addr  = addr;
    while (lsu_pend || ifu_pend) begin
      @(negedge clk);
      cycles++;
      if (cycles > WAIT_LIMIT) fail_run($sformatf("timeout waiting for ready in %s", name));
      if (in_timer && (o_axi_aw_valid || o_axi_w_valid || o_axi_ar_valid)) begin
        fail_run($sformatf("an AXI valid went high during timer access %s", name));
      end
      // load/store is served first, a fetch is always a word
      exp_size = lsu_pend ? size : SIZE_W;
      if (o_axi_ar_valid) check_axi_size(name, {1'b0, exp_size}, o_axi_ar_size);
      if (o_axi_aw_valid) check_axi_size(name, {1'b0, exp_size}, o_axi_aw_size);
      if (lsu_pend && o_lsu_ready) begin
        if (in_timer && cycles != 2) begin
          fail_run($sformatf("timer access %s took %0d cycles instead of 2", name, cycles));
        end
        if (check_data && !wen) check_dword(name, exp, o_lsu_rdata);
        last_rdata  = o_lsu_rdata;
        lsu_pend    = 1'b0;
        i_lsu_valid = 1'b0;
      end
      if (ifu_pend && o_ifu_ready) begin
        if (lsu_pend) fail_run($sformatf("fetch in %s finished before the load/store", name));
        if (check_data) check_instr(name, exp[31:0], o_ifu_instr);
        ifu_pend    = 1'b0;
        i_ifu_valid = 1'b0;
      end
    end
  endtask

  initial begin
    clk         = 1'b0;
    rst_n       = 1'b0;
    i_ifu_valid = 1'b0;
    i_ifu_addr  = '0;
    i_lsu_valid = 1'b0;
    i_lsu_wen   = 1'b0;
    i_lsu_addr  = '0;
    i_lsu_size  = SIZE_B;
    i_lsu_wdata = '0;
    repeat (16) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check_level("reset_timer_int", 1'b0, o_timer_int);
    check_level("reset_ifu_ready", 1'b0, o_ifu_ready);
    check_level("reset_lsu_ready", 1'b0, o_lsu_ready);
    check_level("reset_axi_valid", 1'b0, o_axi_aw_valid | o_axi_w_valid | o_axi_ar_valid);
    check_level("reset_axi_ready", 1'b0, o_axi_r_ready | o_axi_b_ready);

    // merged doubleword after sb and sh is cdef_3344_ab66_7788
    add_row("sd_base", PORT_LSU, 1'b1, 64'h8000_0100, SIZE_D, 64'h1122_3344_5566_7788, '0);
    add_row("ld_base", PORT_LSU, 1'b0, 64'h8000_0100, SIZE_D, '0, 64'h1122_3344_5566_7788);
    add_row("sb_lane3", PORT_LSU, 1'b1, 64'h8000_0103, SIZE_B, 64'hffff_ffff_ffff_ffab, '0);
    add_row("sh_lane6", PORT_LSU, 1'b1, 64'h8000_0106, SIZE_H, 64'h9999_9999_9999_cdef, '0);
    add_row("ld_merged", PORT_LSU, 1'b0, 64'h8000_0100, SIZE_D, '0, 64'hcdef_3344_ab66_7788);
    add_row("lb_lane3", PORT_LSU, 1'b0, 64'h8000_0103, SIZE_B, '0, 64'h0000_0000_0000_00ab);
    add_row("lh_lane6", PORT_LSU, 1'b0, 64'h8000_0106, SIZE_H, '0, 64'h0000_0000_0000_cdef);
    add_row("lw_upper", PORT_LSU, 1'b0, 64'h8000_0104, SIZE_W, '0, 64'h0000_0000_cdef_3344);
    add_row("fetch_low", PORT_IFU, 1'b0, 64'h8000_0100, SIZE_W, '0, 64'h0000_0000_ab66_7788);
    add_row("fetch_high", PORT_IFU, 1'b0, 64'h8000_0104, SIZE_W, '0, 64'h0000_0000_cdef_3344);
    // store wins the race, so the fetch sees the new low word
    add_row("race_store", PORT_BOTH, 1'b1, 64'h8000_0108, SIZE_D, 64'h0bad_f00d_1234_5678,
            64'h0000_0000_1234_5678);
    add_row("race_load", PORT_BOTH, 1'b0, 64'h8000_010c, SIZE_W, '0, 64'h0000_0000_0bad_f00d);
    for (int r = 0; r < row_name.size(); r++) begin
      run_access(row_name[r], row_port[r], row_wen[r], row_addr[r], row_size[r],
                 row_wdata[r], row_exp[r], 1'b1);
    end

    // compare set 40 ticks past the count just read
    run_access("read_mtime", PORT_LSU, 1'b0, TIMER_BASE + MTIME_OFS, SIZE_D, '0, '0, 1'b0);
    cmp_value = last_rdata + 64'd40;
    run_access("write_mtimecmp", PORT_LSU, 1'b1, TIMER_BASE + MTIMECMP_OFS, SIZE_D,
               cmp_value, '0, 1'b1);
    check_level("int_after_cmp_write", 1'b0, o_timer_int);
    wait_cycles = 0;
    while (!o_timer_int) begin
      @(negedge clk);
      wait_cycles++;
      if (wait_cycles > WAIT_LIMIT) fail_run("timeout waiting for the timer interrupt to rise");
    end
    run_access("read_mtimecmp", PORT_LSU, 1'b0, TIMER_BASE + MTIMECMP_OFS, SIZE_D,
               '0, cmp_value, 1'b1);
    check_level("int_held", 1'b1, o_timer_int);
    $display("all tests passed");
    $finish;
  end

endmodule

`default_nettype wire

/* project.f */
design/mem_bus_pkg.sv
design/mem_req_if.sv
design/machine_timer.sv
design/axi_master_fsm.sv
design/bus_arbiter.sv
design/mem_subsys_top.sv
tb/axi_slave_model.sv
tb/tb_mem_subsys.sv
